// ==== hdl/busSizer.sv ====
module busSizer import sizingPkg::*; (
    input  logic        BCLK,
    input  logic        nRESET,
    // CPU side
    input  logic        nTSCpu,
    input  logic        cpuRnW,
    input  transferSize cpuSize,
    input  logic [1:0]  cpuAddr,
    input  longWord     cpuDataIn,
    output logic        nTACpu,
    output longWord     cpuDataOut,
    // Host side
    input  dsackCode    dsack,
    input  longWord     amigaDataIn,
    output logic        nTSAmiga,
    output logic        amigaRnW,
    output logic [1:0]  amigaAddr,
    output longWord     amigaDataOut,
    output byteLanes    nByteEnable
);

    // Latch to sequencer
    logic        cycleReady;
    logic        cycleTaken;
    logic        curRnW;
    transferSize curSize;
    logic [1:0]  curAddr;

    // Sequencer to datapaths
    logic        beatDone;
    logic        lowWordBeat;
    logic        wordPort;
    logic        writeTake;
    logic        drainBeat;
    logic        bufEmpty;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    cycleLatch uLatch (
        .BCLK        (BCLK),
        .nRESET      (nRESET),
        .nTSCpu      (nTSCpu),
        .cpuRnW      (cpuRnW),
        .cpuSize     (cpuSize),
        .cpuAddr     (cpuAddr),
        .cycleTaken  (cycleTaken),
        .cycleReady  (cycleReady),
        .curRnW      (curRnW),
        .curSize     (curSize),
        .curAddr     (curAddr),
        .nByteEnable (nByteEnable)
    );

    transferSequencer uSeq (
        .BCLK        (BCLK),
        .nRESET      (nRESET),
        .cycleReady  (cycleReady),
        .curRnW      (curRnW),
        .curSize     (curSize),
        .curAddr     (curAddr),
        .dsack       (dsack),
        .bufEmpty    (bufEmpty),
        .cycleTaken  (cycleTaken),
        .nTSAmiga    (nTSAmiga),
        .amigaRnW    (amigaRnW),
        .amigaAddr   (amigaAddr),
        .beatDone    (beatDone),
        .lowWordBeat (lowWordBeat),
        .wordPort    (wordPort),
        .readDone    (),
        .writeTake   (writeTake),
        .nTACpu      (nTACpu),
        .drainBeat   (drainBeat)
    );

    ////////////////////////////////////////
    // Datapaths
    ////////////////////////////////////////

    readAssembler uRead (
        .BCLK        (BCLK),
        .nRESET      (nRESET),
        .amigaDataIn (amigaDataIn),
        .beatDone    (beatDone),
        .lowWordBeat (lowWordBeat),
        .wordPort    (wordPort),
        .cpuDataOut  (cpuDataOut)
    );

    writeBuffer uWrite (
        .BCLK         (BCLK),
        .nRESET       (nRESET),
        .cpuDataIn    (cpuDataIn),
        .writeTake    (writeTake),
        .drainBeat    (drainBeat),
        .lowWordBeat  (lowWordBeat),
        .amigaDataOut (amigaDataOut),
        .bufEmpty     (bufEmpty)
    );

endmodule

// ==== hdl/cycleLatch.sv ====
module cycleLatch import sizingPkg::*; (
    input  logic        BCLK,
    input  logic        nRESET,
    input  logic        nTSCpu,
    input  logic        cpuRnW,
    input  transferSize cpuSize,
    input  logic [1:0]  cpuAddr,
    input  logic        cycleTaken,
    output logic        cycleReady,
    output logic        curRnW,
    output transferSize curSize,
    output logic [1:0]  curAddr,
    output byteLanes    nByteEnable
);

    logic        heldRnW;
    transferSize heldSize;
    logic [1:0]  heldAddr;

    // Lane decode, UU lane sits at address 00
    function automatic byteLanes laneDecode(input transferSize size, input logic [1:0] addr);
        byteLanes lanes;
        case (size)
            BYTE:    lanes = ~(4'b1000 >> addr);
            WORD:    lanes = addr[1] ? 4'b1100 : 4'b0011;
            default: lanes = 4'b0000;               // LWORD and LINE use all lanes
        endcase
        return lanes;
    endfunction

    // Pending cycle attributes
    always_ff @(posedge BCLK) begin
        if (!nTSCpu) begin
            heldRnW  <= cpuRnW;
            heldSize <= cpuSize;
            heldAddr <= cpuAddr;
        end
    end

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cycleReady  <= 1'b0;
            curRnW      <= 1'b1;
            curSize     <= LWORD;
            curAddr     <= 2'b00;
            nByteEnable <= 4'b1111;                 // Nothing enabled out of reset
        end else begin
            if (!nTSCpu) begin
                cycleReady <= 1'b1;                 // A new start wins over the take
            end else if (cycleTaken) begin
                cycleReady <= 1'b0;
            end
            // Pending cycle becomes the active one
            if (cycleTaken) begin
                curRnW      <= heldRnW;
                curSize     <= heldSize;
                curAddr     <= heldAddr;
                nByteEnable <= laneDecode(heldSize, heldAddr);
            end
        end
    end

endmodule

// ==== hdl/readAssembler.sv ====
module readAssembler import sizingPkg::*; (
    input  logic    BCLK,
    input  logic    nRESET,
    input  longWord amigaDataIn,
    input  logic    beatDone,
    input  logic    lowWordBeat,
    input  logic    wordPort,
    output longWord cpuDataOut
);

    logic [15:0] portWord;                  // A word port drives D31-D16 only

    assign portWord = amigaDataIn[31:16];

    ////////////////////////////////////////
    // Read assembly
    ////////////////////////////////////////

    // Upper word lands in both halves, so BYTE and WORD reads
    // at any address find their lanes. The low word beat of a
    // long word then overwrites the lower half only.
    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            cpuDataOut <= '0;
        end else if (beatDone) begin
            if (lowWordBeat) begin
                cpuDataOut[15:0] <= portWord;           // Second word, lower half
            end else if (wordPort) begin
                cpuDataOut <= {portWord, portWord};     // Mirror to both halves
            end else begin
                cpuDataOut <= amigaDataIn;              // Long port, all lanes
            end
        end
    end

endmodule

// ==== hdl/sizingPkg.sv ====
package sizingPkg;

    ////////////////////////////////////////
    // Bus encodings
    ////////////////////////////////////////

    // CPU SIZ code, same values as the 68040 pins
    typedef enum logic [1:0] {
        LWORD = 2'b00,
        BYTE  = 2'b01,
        WORD  = 2'b10,
        LINE  = 2'b11
    } transferSize;

    // Host termination code
    typedef enum logic [1:0] {
        LTERM    = 2'b00,           // 32 bit port
        WTERM    = 2'b01,           // 16 bit port
        WAITTERM = 2'b11            // Beat still running
    } dsackCode;

    // Transfer sequencer states
    typedef enum logic [2:0] {
        IDLE,
        START,                      // Attributes valid, dispatch read or write
        WAITACK,                    // Waiting on upper or long beat
        NEXTLONG,                   // Host start cycle of a long word
        LOWWORD                     // Second word on a 16 bit port
    } seqState;

    typedef logic [31:0] longWord;
    typedef logic [3:0]  byteLanes; // Active low, bit 3 is UU

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int LINE_LONGS = 4;              // Long words in a line
    localparam int BUF_PTR_W  = 2;              // Write buffer pointer
    localparam logic [1:0] LOW_WORD_ADDR = 2'b10;

endpackage

// ==== hdl/transferSequencer.sv ====
module transferSequencer import sizingPkg::*; (
    input  logic        BCLK,
    input  logic        nRESET,
    input  logic        cycleReady,
    input  logic        curRnW,
    input  transferSize curSize,
    input  logic [1:0]  curAddr,
    input  dsackCode    dsack,
    input  logic        bufEmpty,
    output logic        cycleTaken,
    output logic        nTSAmiga,
    output logic        amigaRnW,
    output logic [1:0]  amigaAddr,
    output logic        beatDone,
    output logic        lowWordBeat,
    output logic        wordPort,
    output logic        readDone,
    output logic        writeTake,
    output logic        nTACpu,
    output logic        drainBeat
);

    seqState state;
    seqState nextState;

    logic [BUF_PTR_W:0] longCnt;      // CPU takes on writes, then long word index
    logic [BUF_PTR_W:0] longCntNext;
    logic [BUF_PTR_W:0] longTotal;
    logic               lastLong;
    logic               portLatch;
    logic               upperDone;
    logic               longEnd;
    logic               hostStart;
    logic               takeNext;

    ////////////////////////////////////////
    // Beat decode
    ////////////////////////////////////////

    assign longTotal = (curSize == LINE) ? (BUF_PTR_W + 1)'(LINE_LONGS) : (BUF_PTR_W + 1)'(1);
    assign lastLong  = (longCnt == longTotal - 1'b1);

    assign cycleTaken  = (state == IDLE) && cycleReady && bufEmpty;
    assign beatDone    = ((state == WAITACK) || (state == LOWWORD)) && (dsack != WAITTERM);
    // Word port answered the upper half of a long word
    assign upperDone   = (state == WAITACK) && (dsack == WTERM) &&
                         ((curSize == LWORD) || (curSize == LINE));
    assign longEnd     = beatDone && !upperDone;
    assign readDone    = longEnd && curRnW;      // TA follows one cycle later
    assign drainBeat   = longEnd && !curRnW;
    assign lowWordBeat = (state == LOWWORD);
    // Datapaths need the width on the first beat itself
    assign wordPort    = (state == WAITACK) ? (dsack == WTERM) : portLatch;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////

    always_comb begin
        nextState   = state;
        longCntNext = longCnt;
        hostStart   = 1'b0;
        takeNext    = 1'b0;
        case (state)
            IDLE: begin
                if (cycleTaken) begin
                    nextState   = START;
                    longCntNext = '0;
                end
            end
            START: begin
                if (!curRnW && (longCnt != longTotal)) begin
                    takeNext    = 1'b1;             // One CPU ack per long word
                    longCntNext = longCnt + 1'b1;
                end else begin
                    hostStart   = 1'b1;             // Reads go straight out
                    longCntNext = '0;
                    nextState   = NEXTLONG;
                end
            end
            NEXTLONG: nextState = WAITACK;           // nTSAmiga low in this cycle
            WAITACK: begin
                if (upperDone) begin
                    nextState = LOWWORD;
                end
            end
            LOWWORD: nextState = LOWWORD;
            default: nextState = IDLE;
        endcase

        // End of a long word, from either beat state
        if (longEnd) begin
            if (lastLong) begin
                nextState = IDLE;
            end else begin
                hostStart   = 1'b1;
                longCntNext = longCnt + 1'b1;
                nextState   = NEXTLONG;
            end
        end
    end

    ////////////////////////////////////////
    // Registers and bus outputs
    ////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state     <= IDLE;
            longCnt   <= '0;
            portLatch <= 1'b0;
            nTSAmiga  <= 1'b1;
            amigaRnW  <= 1'b1;
            amigaAddr <= 2'b00;
            writeTake <= 1'b0;
            nTACpu    <= 1'b1;
        end else begin
            state     <= nextState;
            longCnt   <= longCntNext;
            writeTake <= takeNext;
            nTACpu    <= !(readDone || takeNext);   // Read ack or write take
            nTSAmiga  <= !(hostStart || upperDone); // One cycle per host start

            if (hostStart) begin
                amigaRnW  <= curRnW;
                amigaAddr <= curAddr;
            end else if (upperDone) begin
                amigaAddr <= LOW_WORD_ADDR;         // Second word of the long word
            end else if (nextState == IDLE) begin
                amigaRnW  <= 1'b1;
            end

            // Port width from the first dsack of the cycle
            if ((state == WAITACK) && beatDone && (longCnt == '0)) begin
                portLatch <= (dsack == WTERM);
            end
        end
    end

endmodule

// ==== hdl/writeBuffer.sv ====
module writeBuffer import sizingPkg::*; (
    input  logic    BCLK,
    input  logic    nRESET,
    input  longWord cpuDataIn,
    input  logic    writeTake,
    input  logic    drainBeat,
    input  logic    lowWordBeat,
    output longWord amigaDataOut,
    output logic    bufEmpty
);

    longWord              bufMem [LINE_LONGS];
    longWord              headLong;
    logic [BUF_PTR_W-1:0] wrPtr;
    logic [BUF_PTR_W-1:0] rdPtr;
    logic [BUF_PTR_W:0]   count;        // Up to LINE_LONGS entries

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge BCLK) begin
        if (writeTake) begin
            bufMem[wrPtr] <= cpuDataIn;     // Captured at the end of the TA cycle
        end
    end

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (writeTake) wrPtr <= wrPtr + 1'b1;
            if (drainBeat) rdPtr <= rdPtr + 1'b1;   // Whole long word gone to host
            case ({writeTake, drainBeat})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // Host lanes
    ////////////////////////////////////////

    assign headLong = bufMem[rdPtr];
    assign bufEmpty = (count == '0);

    // Word port reads D31-D16, so the lower word moves up for its beat
    assign amigaDataOut = lowWordBeat ? {headLong[15:0], headLong[15:0]} : headLong;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the bus sizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/100ps --top-module busSizerTb -f sim.f -o busSizerSim

simOut=$(./obj_dir/busSizerSim 2>&1) || true
echo "$simOut"
echo "$simOut" | grep -q "^all tests passed$"

// ==== sim.f ====
hdl/sizingPkg.sv
hdl/cycleLatch.sv
hdl/transferSequencer.sv
hdl/readAssembler.sv
hdl/writeBuffer.sv
hdl/busSizer.sv
tests/busSizerTb.sv

// ==== tests/busInput.txt ====
// Columns: control word, then data long words 0 to 3
// Control hex digits: RnW, size, address, port (1 = word), wait cycles, held behind previous
// Long port long word reads
100000 11223344 00000000 00000000 00000000
100020 a1b2c3d4 00000000 00000000 00000000
// Word port long word read, then narrow reads
100110 5566aabb 00000000 00000000 00000000
120100 1234abcd 00000000 00000000 00000000
122110 8765fedc 00000000 00000000 00000000
113100 0f1e2d3c 00000000 00000000 00000000
111000 c0ffee11 00000000 00000000 00000000
// Line reads from both port widths
130030 01020304 05060708 090a0b0c 0d0e0f10
130110 f0e1d2c3 b4a59687 78695a4b 3c2d1e0f
// Line writes from both port widths
030020 deadbeef 00c0ffee 13579bdf 2468ace0
030100 89abcdef 76543210 fedcba98 01234567
// Reads started while a write still drains
100101 a5a55a5a 00000000 00000000 00000000
000020 600dcafe 00000000 00000000 00000000
130001 11111111 22222222 33333333 44444444

// ==== tests/busSizerTb.sv ====
module busSizerTb import sizingPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_VECS       = 32;
    localparam int VEC_WORDS      = 5;              // Control word, then four long words
    localparam int CYCLES_PER_VEC = 64;

    logic        BCLK = 1'b0;
    logic        nRESET;
    logic        nTSCpu;
    logic        cpuRnW;
    transferSize cpuSize;
    logic [1:0]  cpuAddr;
    longWord     cpuDataIn;
    logic        nTACpu;
    longWord     cpuDataOut;
    dsackCode    dsack;
    longWord     amigaDataIn;
    logic        nTSAmiga;
    logic        amigaRnW;
    logic [1:0]  amigaAddr;
    longWord     amigaDataOut;
    byteLanes    nByteEnable;

    logic [31:0] vecMem [MAX_VECS*VEC_WORDS];
    int          numVecs;
    int          hostDone   = 0;                    // Vectors fully served by the host
    int          cycleCount = 0;
    int          cycleLimit = CYCLES_PER_VEC;

    busSizer dut (
        .BCLK         (BCLK),
        .nRESET       (nRESET),
        .nTSCpu       (nTSCpu),
        .cpuRnW       (cpuRnW),
        .cpuSize      (cpuSize),
        .cpuAddr      (cpuAddr),
        .cpuDataIn    (cpuDataIn),
        .nTACpu       (nTACpu),
        .cpuDataOut   (cpuDataOut),
        .dsack        (dsack),
        .amigaDataIn  (amigaDataIn),
        .nTSAmiga     (nTSAmiga),
        .amigaRnW     (amigaRnW),
        .amigaAddr    (amigaAddr),
        .amigaDataOut (amigaDataOut),
        .nByteEnable  (nByteEnable)
    );

    always #5 BCLK = ~BCLK;                         // 10 ns period

    always @(posedge BCLK) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
            $display("tests failed");
            $fatal(1, "simulation timed out");
        end
    end

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////

    task automatic checkLong(input longWord got, input longWord exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkAddr(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkLanes(input byteLanes got, input byteLanes exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    ////////////////////////////////////////
    // Expected values
    ////////////////////////////////////////

    function automatic int longsIn(input transferSize size);
        return (size == LINE) ? LINE_LONGS : 1;
    endfunction

    // Active low lanes, address 00 is UU
    function automatic byteLanes expectLanes(input transferSize size, input logic [1:0] addr);
        byteLanes lanes;
        lanes = 4'b0000;                            // Long and line use every lane
        if (size == BYTE) begin
            lanes = 4'b1111;
            lanes[2'd3 - addr] = 1'b0;
        end else if (size == WORD) begin
            lanes = (addr == 2'b00) ? 4'b0011 : 4'b1100;
        end
        return lanes;
    endfunction

    function automatic longWord expectRead(input longWord full, input transferSize size,
                                           input logic [1:0] addr, input logic wordPrt);
        logic [15:0] word;
        word = addr[1] ? full[15:0] : full[31:16];
        // Narrow read from a word port comes back in both halves
        if (wordPrt && ((size == BYTE) || (size == WORD))) begin
            return {word, word};
        end
        return full;
    endfunction

    task automatic decodeVec(input int v, output logic rnw, output transferSize size,
                             output logic [1:0] addr, output logic wordPrt,
                             output int waits, output logic held);
        logic [31:0] ctrl;
        ctrl    = vecMem[v*VEC_WORDS];
        rnw     = ctrl[20];
        size    = transferSize'(ctrl[17:16]);
        addr    = ctrl[13:12];
        wordPrt = ctrl[8];                          // 1 for a 16 bit port
        waits   = int'(ctrl[7:4]);
        held    = ctrl[0];                          // Start while the previous one drains
    endtask

    ////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////

    task automatic runCpu(input int v);
        logic        rnw;
        transferSize size;
        logic [1:0]  addr;
        logic        wordPrt;
        int          waits;
        logic        held;
        int          k;
        longWord     full;
        decodeVec(v, rnw, size, addr, wordPrt, waits, held);
        if (!held) begin
            wait (hostDone >= v);                   // Bus quiet before a fresh start
        end
        @(negedge BCLK);
        nTSCpu  = 1'b0;
        cpuRnW  = rnw;
        cpuSize = size;
        cpuAddr = addr;
        @(negedge BCLK);
        nTSCpu = 1'b1;
        k = 0;
        while (k < longsIn(size)) begin
            @(negedge BCLK);
            if (!nTACpu) begin
                full = vecMem[v*VEC_WORDS + 1 + k];
                if (rnw) begin
                    checkLong(cpuDataOut, expectRead(full, size, addr, wordPrt), "cpuDataOut");
                end else begin
                    cpuDataIn = full;               // Taken at the end of this TA cycle
                end
                k++;
            end else if (!rnw && (k > 0)) begin
                checkFlag(nTACpu, 1'b0, "nTACpu on consecutive write acks");
            end
        end
        @(negedge BCLK);
        checkFlag(nTACpu, 1'b1, "nTACpu after last ack");
    endtask

    ////////////////////////////////////////
    // Host responder
    ////////////////////////////////////////

    task automatic serveVec(input int v);
        logic        rnw;
        transferSize size;
        logic [1:0]  addr;
        logic        wordPrt;
        int          waits;
        logic        held;
        int          beats;
        longWord     full;
        logic [15:0] word;
        decodeVec(v, rnw, size, addr, wordPrt, waits, held);
        beats = (wordPrt && ((size == LWORD) || (size == LINE))) ? 2 : 1;
        for (int l = 0; l < longsIn(size); l++) begin
            full = vecMem[v*VEC_WORDS + 1 + l];
            for (int b = 0; b < beats; b++) begin
                while (nTSAmiga) @(negedge BCLK);   // Host start seen
                checkFlag(amigaRnW, rnw, "amigaRnW");
                checkAddr(amigaAddr, (b == 0) ? addr : LOW_WORD_ADDR, "amigaAddr");
                checkLanes(nByteEnable, expectLanes(size, addr), "nByteEnable");
                if (!rnw && wordPrt) begin
                    word = (b == 0) ? full[31:16] : full[15:0];
                    checkLong(amigaDataOut & 32'hffff0000, {word, 16'h0000}, "amigaDataOut");
                end else if (!rnw) begin
                    checkLong(amigaDataOut, full, "amigaDataOut");
                end
                @(negedge BCLK);
                checkFlag(nTSAmiga, 1'b1, "nTSAmiga one cycle after host start");
                repeat (waits) @(negedge BCLK);
                dsack = wordPrt ? WTERM : LTERM;
                if (wordPrt) begin
                    word        = amigaAddr[1] ? full[15:0] : full[31:16];
                    amigaDataIn = {word, ~word};    // Lower lanes float on a word port
                end else begin
                    amigaDataIn = full;
                end
                @(negedge BCLK);
                dsack = WAITTERM;
            end
        end
        hostDone++;
    endtask

    initial begin : hostSide
        int v;
        @(posedge nRESET);
        @(negedge BCLK);
        for (v = 0; v < numVecs; v++) begin
            serveVec(v);
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : cpuSide
        int v;
        nRESET      = 1'b0;
        nTSCpu      = 1'b1;
        cpuRnW      = 1'b1;
        cpuSize     = LWORD;
        cpuAddr     = 2'b00;
        cpuDataIn   = '0;
        dsack       = WAITTERM;
        amigaDataIn = '0;
        for (v = 0; v < MAX_VECS*VEC_WORDS; v++) begin
            vecMem[v] = {8'hff, 24'(v)};            // Unused rows end the vector list
        end
        $readmemh("tests/busInput.txt", vecMem);
        numVecs = 0;
        while ((numVecs < MAX_VECS) && (vecMem[numVecs*VEC_WORDS][31:24] != 8'hff)) begin
            numVecs++;
        end
        cycleLimit = numVecs * CYCLES_PER_VEC;

        repeat (8) @(negedge BCLK);
        nRESET = 1'b1;
        @(negedge BCLK);
        checkFlag(nTACpu, 1'b1, "nTACpu after reset");
        checkFlag(nTSAmiga, 1'b1, "nTSAmiga after reset");
        checkLanes(nByteEnable, 4'b1111, "nByteEnable after reset");

        for (v = 0; v < numVecs; v++) begin
            runCpu(v);
        end
        wait (hostDone == numVecs);
        @(negedge BCLK);
        $display("all tests passed");
        $finish;
    end

endmodule
